/* logic/btc_enc_col_code.sv */
/*
  column coder, one bit lane of the column spc code
  walks down a column, passes the bits and puts the column parity
  in the last slot (row K); eight of them run side by side
*/
`timescale 1ns/1ps

module btc_enc_col_code (
  input  logic                    iclk    ,
  input  logic                    ireset  ,
  input  logic                    iclkena ,
  //
  input  btc_pkg::btc_code_mode_t imode   ,
  //
  input  btc_pkg::btc_strobe_t    istrb   ,
  input  logic                    idat    ,
  //
  output btc_pkg::btc_strobe_t    ostrb   ,
  output logic                    odat
);

  import btc_pkg::*;

  // parity of the column so far
  logic parity;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ostrb <= '0;
    end
    else if (iclkena) begin
      ostrb <= istrb;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      // top of column drops the old sum
      if (istrb.val) begin
        parity <= idat ^ (parity & !istrb.sop);
      end
      odat <= (istrb.eop && imode == code_spc) ? parity : idat;
    end
  end

endmodule

/* logic/btc_enc_ctrl.sv */
/*
  pass sequencer of the encoder engine
  idle -> row pass -> drain -> column pass -> drain -> output pass
  generates buffer addresses, slot strobes for the coders, the row/column
  select and the output write strobes; modes are taken at block start
*/
`timescale 1ns/1ps

module btc_enc_ctrl (
  input  logic                        iclk          ,
  input  logic                        ireset        ,
  input  logic                        iclkena       ,
  //
  input  btc_pkg::btc_mode_t          imode         ,
  //
  input  logic                        irbuf_full    ,
  output logic                        orempty       ,
  input  logic                        iwbuf_empty   ,
  //
  output logic [btc_pkg::cADDR_W-1:0] obuf_addr     ,
  output logic                        orow_mode     ,
  //
  input  logic                        irow_enc_busy ,
  output btc_pkg::btc_strobe_t        orow_strb     ,
  input  logic                        icol_enc_busy ,
  output btc_pkg::btc_strobe_t        ocol_strb     ,
  //
  output logic                        owrite        ,
  output logic                        owfull
);

  import btc_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_row,
    s_row_drain,
    s_col,
    s_col_drain,
    s_out
  } state_t;

  state_t            state;
  btc_mode_t         mode;
  logic [cCNT_W-1:0] row_cnt;
  logic [cCNT_W-1:0] col_cnt;
  logic [1:0]        drain_cnt;

  // block geometry, all as last index
  logic [cCNT_W-1:0] k_last;
  logic [cCNT_W-1:0] c_last;
  logic [cCNT_W-1:0] r_last;

  logic              row_end;
  logic              col_end;
  logic              drain_done;

  // --------------------
  // geometry
  // --------------------

  always_comb begin
    k_last = (mode.smode == short_full) ? cCNT_W'(cK_FULL - 1) : cCNT_W'(cK_SMALL - 1);
    // spc adds one column / one row
    c_last = k_last + cCNT_W'(mode.xmode == code_spc);
    r_last = k_last + cCNT_W'(mode.ymode == code_spc);
  end

  assign row_end    = (col_cnt == c_last);
  // column pass only runs with ymode spc, so R-1 is row K
  assign col_end    = (row_cnt == r_last);
  // coder output lands cRD_LAT + 1 ticks after the last slot
  assign drain_done = (drain_cnt == 2'(cRD_LAT + 1));

  // --------------------
  // pass FSM
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= s_idle;
      mode      <= '0;
      row_cnt   <= '0;
      col_cnt   <= '0;
      drain_cnt <= '0;
      orempty   <= 1'b0;
    end
    else if (iclkena) begin
      // tick after the last input buffer read
      orempty <= (state == s_row) && row_end && (row_cnt == k_last);
      // drain timer
      if (state == s_row_drain || state == s_col_drain) begin
        if (!drain_done) begin
          drain_cnt <= drain_cnt + 1'b1;
        end
      end
      else begin
        drain_cnt <= '0;
      end
      case (state)
        s_idle : begin
          mode    <= imode;
          row_cnt <= '0;
          col_cnt <= '0;
          if (irbuf_full && iwbuf_empty) begin
            state <= s_row;
          end
        end
        // data rows only, columns inner
        s_row, s_out : begin
          col_cnt <= row_end ? '0 : col_cnt + 1'b1;
          if (row_end) begin
            row_cnt <= row_cnt + 1'b1;
            if (state == s_row && row_cnt == k_last) begin
              state <= s_row_drain;
            end
            if (state == s_out && row_cnt == r_last) begin
              state <= s_idle;
            end
          end
        end
        s_row_drain : begin
          row_cnt <= '0;
          col_cnt <= '0;
          if (drain_done && !irow_enc_busy) begin
            state <= (mode.ymode == code_spc) ? s_col : s_out;
          end
        end
        // rows inner, row K is the parity slot
        s_col : begin
          row_cnt <= col_end ? '0 : row_cnt + 1'b1;
          if (col_end) begin
            col_cnt <= col_cnt + 1'b1;
            if (col_cnt == c_last) begin
              state <= s_col_drain;
            end
          end
        end
        s_col_drain : begin
          row_cnt <= '0;
          col_cnt <= '0;
          if (drain_done && !icol_enc_busy) begin
            state <= s_out;
          end
        end
        default : begin
          state <= s_idle;
        end
      endcase
    end
  end

  // --------------------
  // outputs
  // --------------------

  assign obuf_addr = cADDR_W'(row_cnt * cROW_STRIDE + col_cnt);
  // held through the drain, ram write mux follows it
  assign orow_mode = (state == s_row) || (state == s_row_drain);

  always_comb begin
    orow_strb.val = (state == s_row);
    orow_strb.sop = (state == s_row) && (col_cnt == '0);
    orow_strb.eop = (state == s_row) && row_end;
    ocol_strb.val = (state == s_col);
    ocol_strb.sop = (state == s_col) && (row_cnt == '0);
    ocol_strb.eop = (state == s_col) && col_end;
  end

  assign owrite = (state == s_out);
  assign owfull = (state == s_out) && row_end && (row_cnt == r_last);

endmodule

/* logic/btc_enc_engine.sv */
/*
  encoder engine, sequencer + row coder + 8 column coders + codeword ram
  control is delayed cRD_LAT ticks to meet the ram read data, coders add
  one tick and the ram write reg one more; the output port follows the
  sequencer write strobe by three ticks, tag and modes ride with the block
*/
`timescale 1ns/1ps

module btc_enc_engine (
  input  logic                        iclk        ,
  input  logic                        ireset      ,
  input  logic                        iclkena     ,
  //
  input  btc_pkg::btc_mode_t          imode       ,
  //
  input  logic                        irbuf_full  ,
  input  logic [btc_pkg::cDAT_W-1:0]  irdat       ,
  input  logic [btc_pkg::cTAG_W-1:0]  irtag       ,
  output logic                        oread       ,
  output logic                        orempty     ,
  output logic [btc_pkg::cADDR_W-1:0] oraddr      ,
  //
  input  logic                        iwbuf_empty ,
  //
  output logic                        owrite      ,
  output logic                        owfull      ,
  output logic [btc_pkg::cADDR_W-1:0] owaddr      ,
  output logic [btc_pkg::cDAT_W-1:0]  owdat       ,
  output logic [btc_pkg::cTAG_W-1:0]  owtag       ,
  output btc_pkg::btc_mode_t          omode
);

  import btc_pkg::*;

  // ctrl
  logic [cADDR_W-1:0] ctrl__obuf_addr;
  logic               ctrl__orow_mode;
  btc_strobe_t        ctrl__orow_strb;
  btc_strobe_t        ctrl__ocol_strb;
  logic               ctrl__owrite;
  logic               ctrl__owfull;

  // row coder
  btc_strobe_t        row_code__istrb;
  btc_strobe_t        row_code__ostrb;
  logic [cDAT_W-1:0]  row_code__odat;

  // column coders, one per bit lane
  btc_strobe_t        col_code__istrb;
  btc_strobe_t        col_code__ostrb [cDAT_W];
  logic [cDAT_W-1:0]  col_code__odat;
  logic [cDAT_W-1:0]  col_code__busy;

  // codeword ram
  logic               mem__iwrite;
  logic [cADDR_W-1:0] mem__iwaddr;
  logic [cDAT_W-1:0]  mem__iwdat;
  logic [cDAT_W-1:0]  mem__ordat;

  // align lines
  btc_strobe_t        strb_line [cRD_LAT];
  logic [cRD_LAT-1:0] write_line;
  logic [cRD_LAT-1:0] wfull_line;
  logic [cADDR_W-1:0] addr_line [cRD_LAT+1];

  // tag and modes of the block in flight
  logic [cTAG_W-1:0]  blk_tag;
  btc_mode_t          blk_mode;

  // --------------------
  // sequencer
  // --------------------

  btc_enc_ctrl ctrl (
    .iclk          ( iclk                 ) ,
    .ireset        ( ireset               ) ,
    .iclkena       ( iclkena              ) ,
    .imode         ( imode                ) ,
    .irbuf_full    ( irbuf_full           ) ,
    .orempty       ( orempty              ) ,
    .iwbuf_empty   ( iwbuf_empty          ) ,
    .obuf_addr     ( ctrl__obuf_addr      ) ,
    .orow_mode     ( ctrl__orow_mode      ) ,
    .irow_enc_busy ( row_code__ostrb.val  ) ,
    .orow_strb     ( ctrl__orow_strb      ) ,
    .icol_enc_busy ( |col_code__busy      ) ,
    .ocol_strb     ( ctrl__ocol_strb      ) ,
    .owrite        ( ctrl__owrite         ) ,
    .owfull        ( ctrl__owfull         )
  );

  // spc parity slot of a row reads nothing
  assign oread  = ctrl__orow_strb.val && !(ctrl__orow_strb.eop && imode.xmode == code_spc);
  assign oraddr = ctrl__obuf_addr;

  // --------------------
  // align lines
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      strb_line  <= '{default : '0};
      write_line <= '0;
      wfull_line <= '0;
    end
    else if (iclkena) begin
      strb_line[0] <= ctrl__orow_mode ? ctrl__orow_strb : ctrl__ocol_strb;
      for (int i = 1; i < cRD_LAT; i++) begin
        strb_line[i] <= strb_line[i-1];
      end
      write_line <= {write_line[cRD_LAT-2:0], ctrl__owrite};
      wfull_line <= {wfull_line[cRD_LAT-2:0], ctrl__owfull};
    end
  end

  // one extra stage, coder delay before the ram write
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      addr_line[0] <= ctrl__obuf_addr;
      for (int i = 1; i <= cRD_LAT; i++) begin
        addr_line[i] <= addr_line[i-1];
      end
    end
  end

  // --------------------
  // coders
  // --------------------

  always_comb begin
    row_code__istrb     = strb_line[cRD_LAT-1];
    row_code__istrb.val = strb_line[cRD_LAT-1].val && ctrl__orow_mode;
    col_code__istrb     = strb_line[cRD_LAT-1];
    col_code__istrb.val = strb_line[cRD_LAT-1].val && !ctrl__orow_mode;
  end

  btc_enc_row_code row_code (
    .iclk    ( iclk            ) ,
    .ireset  ( ireset          ) ,
    .iclkena ( iclkena         ) ,
    .imode   ( blk_mode.xmode  ) ,
    .istrb   ( row_code__istrb ) ,
    .idat    ( irdat           ) ,
    .ostrb   ( row_code__ostrb ) ,
    .odat    ( row_code__odat  )
  );

  for (genvar g = 0; g < cDAT_W; g++) begin : col_code_gen
    btc_enc_col_code col_code (
      .iclk    ( iclk               ) ,
      .ireset  ( ireset             ) ,
      .iclkena ( iclkena            ) ,
      .imode   ( blk_mode.ymode     ) ,
      .istrb   ( col_code__istrb    ) ,
      .idat    ( mem__ordat[g]      ) ,
      .ostrb   ( col_code__ostrb[g] ) ,
      .odat    ( col_code__odat[g]  )
    );
    assign col_code__busy[g] = col_code__ostrb[g].val;
  end

  // --------------------
  // codeword ram
  // --------------------

  codec_mem_block mem (
    .iclk    ( iclk            ) ,
    .ireset  ( ireset          ) ,
    .iclkena ( iclkena         ) ,
    .iwrite  ( mem__iwrite     ) ,
    .iwaddr  ( mem__iwaddr     ) ,
    .iwdat   ( mem__iwdat      ) ,
    .iraddr  ( ctrl__obuf_addr ) ,
    .ordat   ( mem__ordat      )
  );

  // coders are never active together
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      mem__iwrite <= 1'b0;
    end
    else if (iclkena) begin
      mem__iwrite <= row_code__ostrb.val | col_code__busy[0];
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      mem__iwdat  <= row_code__ostrb.val ? row_code__odat : col_code__odat;
      mem__iwaddr <= addr_line[cRD_LAT];
    end
  end

  // --------------------
  // output mapping
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      owrite <= 1'b0;
      owfull <= 1'b0;
    end
    else if (iclkena) begin
      owrite <= write_line[cRD_LAT-1];
      owfull <= wfull_line[cRD_LAT-1];
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      owdat  <= mem__ordat;
      owaddr <= addr_line[cRD_LAT-1];
      // first word of the block
      if (write_line[cRD_LAT-1] && !owrite) begin
        owtag <= blk_tag;
        omode <= blk_mode;
      end
      // word 0 is read once per block, host side still stable
      if (oread && oraddr == '0) begin
        blk_tag  <= irtag;
        blk_mode <= imode;
      end
    end
  end

endmodule

/* logic/btc_enc_row_code.sv */
/*
  row coder, word wide single parity check
  passes the data words of a row one tick later
  with spc the row's last slot is replaced by the xor of its data words
  ostrb.val doubles as the busy level for the sequencer
*/
`timescale 1ns/1ps

module btc_enc_row_code (
  input  logic                       iclk    ,
  input  logic                       ireset  ,
  input  logic                       iclkena ,
  //
  input  btc_pkg::btc_code_mode_t    imode   ,
  //
  input  btc_pkg::btc_strobe_t       istrb   ,
  input  logic [btc_pkg::cDAT_W-1:0] idat    ,
  //
  output btc_pkg::btc_strobe_t       ostrb   ,
  output logic [btc_pkg::cDAT_W-1:0] odat
);

  import btc_pkg::*;

  // running xor of the row, per bit lane
  logic [cDAT_W-1:0] parity;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ostrb <= '0;
    end
    else if (iclkena) begin
      ostrb <= istrb;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      // sop restarts the sum
      if (istrb.val) begin
        parity <= istrb.sop ? idat : (parity ^ idat);
      end
      // parity slot, the word on idat there was never read
      if (istrb.val && istrb.eop && imode == code_spc) begin
        odat <= parity;
      end
      else begin
        odat <= idat;
      end
    end
  end

endmodule

/* logic/btc_enc_top.sv */
/*
  encoder subsystem top
  the host loads one block into the input buffer, then pulses load_done
  with the tag and modes; the block-full flag clears on the engine's
  read-empty pulse, the codeword leaves on the owrite port
*/
`timescale 1ns/1ps

module btc_enc_top (
  input  logic                        iclk       ,
  input  logic                        ireset     ,
  input  logic                        iclkena    ,
  //
  input  logic                        load_write ,
  input  logic [btc_pkg::cADDR_W-1:0] load_addr  ,
  input  logic [btc_pkg::cDAT_W-1:0]  load_dat   ,
  input  logic                        load_done  ,
  input  logic [btc_pkg::cTAG_W-1:0]  load_tag   ,
  input  btc_pkg::btc_mode_t          load_mode  ,
  //
  input  logic                        wbuf_empty ,
  //
  output logic                        owrite     ,
  output logic                        owfull     ,
  output logic [btc_pkg::cADDR_W-1:0] owaddr     ,
  output logic [btc_pkg::cDAT_W-1:0]  owdat      ,
  output logic [btc_pkg::cTAG_W-1:0]  owtag      ,
  output btc_pkg::btc_mode_t          omode
);

  import btc_pkg::*;

  logic               rbuf_full;
  logic [cTAG_W-1:0]  rbuf_tag;
  btc_mode_t          rbuf_mode;
  logic [cADDR_W-1:0] rbuf_raddr;
  logic [cDAT_W-1:0]  rbuf_rdat;
  logic               rbuf_empty;

  // host input buffer
  codec_mem_block rbuf (
    .iclk    ( iclk       ) ,
    .ireset  ( ireset     ) ,
    .iclkena ( iclkena    ) ,
    .iwrite  ( load_write ) ,
    .iwaddr  ( load_addr  ) ,
    .iwdat   ( load_dat   ) ,
    .iraddr  ( rbuf_raddr ) ,
    .ordat   ( rbuf_rdat  )
  );

  // set by the host, cleared once the row pass has read everything
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rbuf_full <= 1'b0;
    end
    else if (iclkena) begin
      if (load_done) begin
        rbuf_full <= 1'b1;
      end
      else if (rbuf_empty) begin
        rbuf_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && load_done) begin
      rbuf_tag  <= load_tag;
      rbuf_mode <= load_mode;
    end
  end

  btc_enc_engine engine (
    .iclk        ( iclk       ) ,
    .ireset      ( ireset     ) ,
    .iclkena     ( iclkena    ) ,
    .imode       ( rbuf_mode  ) ,
    .irbuf_full  ( rbuf_full  ) ,
    .irdat       ( rbuf_rdat  ) ,
    .irtag       ( rbuf_tag   ) ,
    .oread       (            ) ,
    .orempty     ( rbuf_empty ) ,
    .oraddr      ( rbuf_raddr ) ,
    .iwbuf_empty ( wbuf_empty ) ,
    .owrite      ( owrite     ) ,
    .owfull      ( owfull     ) ,
    .owaddr      ( owaddr     ) ,
    .owdat       ( owdat      ) ,
    .owtag       ( owtag      ) ,
    .omode       ( omode      )
  );

endmodule

/* logic/btc_pkg.sv */
/*
  shared definitions of the block turbo code encoder
  code modes, block geometry and the packed structs that pass between
  the host side, the pass sequencer and the coders
  imported by every rtl module that needs a width, a mode or a strobe
*/
package btc_pkg;

  // --------------------
  // geometry
  // --------------------

  // word width, one bit lane per column coder
  localparam int cDAT_W      = 8;
  // words per buffer row, address = row * stride + col
  localparam int cROW_STRIDE = 8;
  localparam int cADDR_W     = 6;
  // row/col counters, up to 8 codeword rows or columns
  localparam int cCNT_W      = 3;
  // data rows and data words per row
  localparam int cK_SMALL    = 3;
  localparam int cK_FULL     = 7;
  // ram read, address reg + output reg
  localparam int cRD_LAT     = 2;
  localparam int cTAG_W      = 8;

  // --------------------
  // modes
  // --------------------

  // component code of one axis
  typedef enum logic {
    code_none = 1'b0,
    code_spc  = 1'b1
  } btc_code_mode_t;

  // shortening, 3x3 or 7x7 data words
  typedef enum logic {
    short_small = 1'b0,
    short_full  = 1'b1
  } btc_short_mode_t;

  // modes of one block
  typedef struct packed {
    btc_code_mode_t  xmode;
    btc_code_mode_t  ymode;
    btc_short_mode_t smode;
  } btc_mode_t;

  // per slot strobes, sequencer -> coders
  typedef struct packed {
    logic sop;
    logic eop;
    logic val;
  } btc_strobe_t;

endpackage

/* logic/codec_mem_block.sv */
/*
  simple dual port ram, one write port and one registered read port
  read data comes two ticks after the read address
  serves as the host input buffer and as the engine's codeword buffer
*/
`timescale 1ns/1ps

module codec_mem_block (
  input  logic                        iclk    ,
  input  logic                        ireset  ,
  input  logic                        iclkena ,
  //
  input  logic                        iwrite  ,
  input  logic [btc_pkg::cADDR_W-1:0] iwaddr  ,
  input  logic [btc_pkg::cDAT_W-1:0]  iwdat   ,
  //
  input  logic [btc_pkg::cADDR_W-1:0] iraddr  ,
  output logic [btc_pkg::cDAT_W-1:0]  ordat
);

  import btc_pkg::*;

  // one word per address
  logic [cDAT_W-1:0]  mem [2**cADDR_W];
  logic [cADDR_W-1:0] raddr;

  // read address reg, first read tick
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      raddr <= '0;
    end
    else if (iclkena) begin
      raddr <= iraddr;
    end
  end

  // write port and output reg, second read tick
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (iwrite) begin
        mem[iwaddr] <= iwdat;
      end
      ordat <= mem[raddr];
    end
  end

endmodule

/* project.f */
logic/btc_pkg.sv
logic/codec_mem_block.sv
logic/btc_enc_row_code.sv
logic/btc_enc_col_code.sv
logic/btc_enc_ctrl.sv
logic/btc_enc_engine.sv
logic/btc_enc_top.sv
test/btc_enc_props.sv
test/btc_enc_tb.sv

/* test/btc_enc_props.sv */
/*
  concurrent checks on the encoder engine's output port and pulses
  bound into every btc_enc_engine instance
*/
`timescale 1ns/1ps

module btc_enc_props (
  input logic                        iclk    ,
  input logic                        ireset  ,
  input logic                        owrite  ,
  input logic                        owfull  ,
  input logic                        orempty ,
  input logic [btc_pkg::cADDR_W-1:0] owaddr
);

  import btc_pkg::*;

  // owfull only comes with the last word
  a_wfull_with_write : assert property (
    @(posedge iclk) disable iff (ireset) owfull |-> owrite
  ) else $error("owfull high without owrite");

  // read-empty is a one tick pulse
  a_rempty_single : assert property (
    @(posedge iclk) disable iff (ireset) orempty |=> !orempty
  ) else $error("orempty held longer than one tick");

  // owaddr steps to the next column or to the next row start
  a_addr_order : assert property (
    @(posedge iclk) disable iff (ireset)
    (owrite && $past(owrite)) |->
      ((int'(owaddr) == int'($past(owaddr)) + 1) ||
       (int'(owaddr) == (int'($past(owaddr)) / cROW_STRIDE + 1) * cROW_STRIDE))
  ) else $error("owaddr does not follow row order");

  a_no_write_in_reset : assert property (
    @(posedge iclk) ireset |-> !owrite
  ) else $error("owrite high during reset");

endmodule

bind btc_enc_engine btc_enc_props props (
  .iclk    ( iclk    ) ,
  .ireset  ( ireset  ) ,
  .owrite  ( owrite  ) ,
  .owfull  ( owfull  ) ,
  .orempty ( orempty ) ,
  .owaddr  ( owaddr  )
);

/* test/btc_enc_tb.sv */
/*
  testbench of the block turbo code encoder top
  loads random blocks through the host port, runs them through the
  engine and checks every owrite word against a reference encoder
  compile with project.f, top module btc_enc_tb
*/
`timescale 1ns/1ps

module btc_enc_tb;

  import btc_pkg::*;

  localparam int cWORDS   = 2**cADDR_W;
  localparam int cTIMEOUT = 2000;
  // ticks the second block is held back in the two block test
  localparam int cHOLD    = 100;

  logic               iclk;
  logic               ireset;
  logic               iclkena;
  logic               load_write;
  logic [cADDR_W-1:0] load_addr;
  logic [cDAT_W-1:0]  load_dat;
  logic               load_done;
  logic [cTAG_W-1:0]  load_tag;
  btc_mode_t          load_mode;
  logic               wbuf_empty;
  logic               owrite;
  logic               owfull;
  logic [cADDR_W-1:0] owaddr;
  logic [cDAT_W-1:0]  owdat;
  logic [cTAG_W-1:0]  owtag;
  btc_mode_t          omode;

  // block under test and its expected codeword
  logic [cDAT_W-1:0]  load_data [cWORDS];
  logic [cDAT_W-1:0]  ref_cw    [cWORDS];
  logic [cADDR_W-1:0] exp_addr  [cWORDS];
  int                 exp_len;
  logic [cTAG_W-1:0]  exp_tag;
  btc_mode_t          exp_mode;
  // words as they came out, by address
  logic [cDAT_W-1:0]  rx_word   [cWORDS];

  int                 rx_cnt;
  int                 full_cnt;
  int                 err_cnt;
  int                 test_cnt;
  int                 test_fail_cnt;
  logic [31:0]        lcg_state;
  logic               abort_run;

  btc_enc_top uut (
    .iclk       ( iclk       ) ,
    .ireset     ( ireset     ) ,
    .iclkena    ( iclkena    ) ,
    .load_write ( load_write ) ,
    .load_addr  ( load_addr  ) ,
    .load_dat   ( load_dat   ) ,
    .load_done  ( load_done  ) ,
    .load_tag   ( load_tag   ) ,
    .load_mode  ( load_mode  ) ,
    .wbuf_empty ( wbuf_empty ) ,
    .owrite     ( owrite     ) ,
    .owfull     ( owfull     ) ,
    .owaddr     ( owaddr     ) ,
    .owdat      ( owdat      ) ,
    .owtag      ( owtag      ) ,
    .omode      ( omode      )
  );

  initial begin
    iclk = 1'b0;
    forever #20 iclk = ~iclk;
  end

  // --------------------
  // reference model
  // --------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic btc_mode_t build_mode(input btc_code_mode_t x, input btc_code_mode_t y,
                                           input btc_short_mode_t s);
    btc_mode_t m;
    m.xmode = x;
    m.ymode = y;
    m.smode = s;
    return m;
  endfunction

  // data copy, row spc in column K, column spc in row K, then row order
  function automatic void btc_ref_encode(input btc_mode_t mode);
    int          k;
    int          rows;
    int          cols;
    logic [7:0]  acc;
    k    = (mode.smode == short_full) ? cK_FULL : cK_SMALL;
    cols = (mode.xmode == code_spc) ? k + 1 : k;
    rows = (mode.ymode == code_spc) ? k + 1 : k;
    for (int r = 0; r < k; r++) begin
      for (int c = 0; c < k; c++) begin
        ref_cw[r*cROW_STRIDE + c] = load_data[r*cROW_STRIDE + c];
      end
    end
    if (mode.xmode == code_spc) begin
      for (int r = 0; r < k; r++) begin
        acc = '0;
        for (int c = 0; c < k; c++) begin
          acc ^= ref_cw[r*cROW_STRIDE + c];
        end
        ref_cw[r*cROW_STRIDE + k] = acc;
      end
    end
    // parity row covers the parity column too
    if (mode.ymode == code_spc) begin
      for (int c = 0; c < cols; c++) begin
        acc = '0;
        for (int r = 0; r < k; r++) begin
          acc ^= ref_cw[r*cROW_STRIDE + c];
        end
        ref_cw[k*cROW_STRIDE + c] = acc;
      end
    end
    exp_len = 0;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        exp_addr[exp_len] = cADDR_W'(r*cROW_STRIDE + c);
        exp_len++;
      end
    end
  endfunction

  // --------------------
  // output compare
  // --------------------

  // outputs move on the rising edge, sampled on the falling one
  always @(negedge iclk) begin
    if (owrite) begin
      if (rx_cnt >= exp_len) begin
        $display("unexpected owrite at address %h, no word expected", owaddr);
        err_cnt++;
      end
      else begin
        if (owaddr !== exp_addr[rx_cnt]) begin
          $display("MISMATCH owaddr: got %h expected %h", owaddr, exp_addr[rx_cnt]);
          err_cnt++;
        end
        if (owdat !== ref_cw[exp_addr[rx_cnt]]) begin
          $display("MISMATCH owdat at %h: got %h expected %h",
                   exp_addr[rx_cnt], owdat, ref_cw[exp_addr[rx_cnt]]);
          err_cnt++;
        end
        if (owtag !== exp_tag) begin
          $display("MISMATCH owtag: got %h expected %h", owtag, exp_tag);
          err_cnt++;
        end
        if (omode !== exp_mode) begin
          $display("MISMATCH omode: got %h expected %h", omode, exp_mode);
          err_cnt++;
        end
        if (owfull && rx_cnt != exp_len - 1) begin
          $display("owfull on word %0d of %0d, not on the last word", rx_cnt, exp_len);
          err_cnt++;
        end
      end
      rx_word[owaddr] = owdat;
      if (owfull) begin
        full_cnt++;
      end
      rx_cnt++;
    end
    else if (owfull) begin
      $display("owfull pulsed without owrite");
      err_cnt++;
    end
  end

  // --------------------
  // block handling
  // --------------------

  task automatic prepare_block(input logic [cTAG_W-1:0] tag, input btc_mode_t mode);
    for (int a = 0; a < cWORDS; a++) begin
      lcg_state    = lcg_next(lcg_state);
      load_data[a] = lcg_state[23:16];
      rx_word[a]   = '0;
    end
    btc_ref_encode(mode);
    exp_tag  = tag;
    exp_mode = mode;
    rx_cnt   = 0;
    full_cnt = 0;
  endtask

  // whole buffer, then the load_done pulse with tag and modes
  task automatic load_block();
    for (int a = 0; a < cWORDS; a++) begin
      @(negedge iclk);
      load_write = 1'b1;
      load_addr  = cADDR_W'(a);
      load_dat   = load_data[a];
    end
    @(negedge iclk);
    load_write = 1'b0;
    load_done  = 1'b1;
    load_tag   = exp_tag;
    load_mode  = exp_mode;
    @(negedge iclk);
    load_done  = 1'b0;
  endtask

  task automatic wait_block_done(input int max_cycles);
    int n;
    n = 0;
    while (!abort_run && full_cnt == 0 && n < max_cycles) begin
      @(posedge iclk);
      n++;
    end
    if (!abort_run && full_cnt == 0) begin
      $display("timeout, no owfull within %0d cycles", max_cycles);
      err_cnt++;
      abort_run = 1'b1;
    end
    // let stray words show up
    repeat (4) @(posedge iclk);
  endtask

  task automatic check_block_counts();
    if (rx_cnt != exp_len) begin
      $display("received %0d words, expected %0d", rx_cnt, exp_len);
      err_cnt++;
    end
    if (full_cnt != 1) begin
      $display("saw %0d owfull pulses in the block, expected one", full_cnt);
      err_cnt++;
    end
  endtask

  task automatic run_block(input logic [cTAG_W-1:0] tag, input btc_mode_t mode);
    if (!abort_run) begin
      prepare_block(tag, mode);
      load_block();
      wait_block_done(cTIMEOUT);
      check_block_counts();
    end
  endtask

  // full 8x8 codeword, every row and column sums to zero
  task automatic check_zero_xor();
    logic [7:0] row_acc;
    logic [7:0] col_acc;
    for (int i = 0; i < cROW_STRIDE; i++) begin
      row_acc = '0;
      col_acc = '0;
      for (int j = 0; j < cROW_STRIDE; j++) begin
        row_acc ^= rx_word[i*cROW_STRIDE + j];
        col_acc ^= rx_word[j*cROW_STRIDE + i];
      end
      if (row_acc !== 8'h00) begin
        $display("row %0d of the codeword does not xor to zero, sum %h", i, row_acc);
        err_cnt++;
      end
      if (col_acc !== 8'h00) begin
        $display("column %0d of the codeword does not xor to zero, sum %h", i, col_acc);
        err_cnt++;
      end
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end
    else begin
      test_fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial begin
    int errs;
    ireset        = 1'b1;
    iclkena       = 1'b1;
    load_write    = 1'b0;
    load_addr     = '0;
    load_dat      = '0;
    load_done     = 1'b0;
    load_tag      = '0;
    load_mode     = '0;
    wbuf_empty    = 1'b1;
    lcg_state     = 32'h713e;
    exp_len       = 0;
    exp_tag       = '0;
    exp_mode      = '0;
    rx_cnt        = 0;
    full_cnt      = 0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    abort_run     = 1'b0;
    repeat (16) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;

    // quiet port after reset, then one owfull per block
    errs = err_cnt;
    repeat (8) begin
      @(negedge iclk);
      if (owrite !== 1'b0) begin
        $display("MISMATCH owrite: got %h expected 0", owrite);
        err_cnt++;
      end
      if (owfull !== 1'b0) begin
        $display("MISMATCH owfull: got %h expected 0", owfull);
        err_cnt++;
      end
    end
    run_block(8'h06, build_mode(code_none, code_none, short_small));
    end_test("reset state and single owfull", errs);

    errs = err_cnt;
    run_block(8'h11, build_mode(code_spc, code_spc, short_full));
    if (!abort_run) begin
      check_zero_xor();
    end
    end_test("full block, spc on both axes", errs);

    errs = err_cnt;
    run_block(8'h22, build_mode(code_spc, code_spc, short_small));
    end_test("small block, spc on both axes", errs);

    errs = err_cnt;
    run_block(8'h33, build_mode(code_spc, code_none, short_full));
    run_block(8'h34, build_mode(code_none, code_spc, short_small));
    end_test("single axis parity", errs);

    // reference is a copy here, checked against the loaded data directly
    errs = err_cnt;
    run_block(8'h44, build_mode(code_none, code_none, short_full));
    for (int a = 0; a < cWORDS; a++) begin
      if (!abort_run && a / cROW_STRIDE < cK_FULL && a % cROW_STRIDE < cK_FULL) begin
        if (rx_word[a] !== load_data[a]) begin
          $display("MISMATCH owdat at %h: got %h expected %h", a, rx_word[a], load_data[a]);
          err_cnt++;
        end
      end
    end
    end_test("uncoded copy", errs);

    // second block waits for wbuf_empty
    errs = err_cnt;
    run_block(8'h5a, build_mode(code_spc, code_spc, short_small));
    if (!abort_run) begin
      prepare_block(8'ha7, build_mode(code_spc, code_none, short_full));
      @(negedge iclk);
      wbuf_empty = 1'b0;
      load_block();
      repeat (cHOLD) @(posedge iclk);
      if (rx_cnt != 0) begin
        $display("%0d words came out while wbuf_empty was low", rx_cnt);
        err_cnt++;
      end
      @(negedge iclk);
      wbuf_empty = 1'b1;
      wait_block_done(cTIMEOUT);
      check_block_counts();
    end
    end_test("two blocks, tags, modes and wbuf_empty hold", errs);

    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end
    else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
